/* Bender.yml */
package:
  name: retire_core

sources:
  - files:
      - design/retire_pkg.sv
      - design/reg_write_if.sv
      - design/pipe_reg.sv
      - design/regfile.sv
      - design/hilo_unit.sv
      - design/writeback.sv
      - design/retire_core.sv
  - target: test
    files:
      - testbench/retire_checker.sv
      - testbench/tb_retire.sv

/* design/hilo_unit.sv */
`timescale 1ns/1ps

module hilo_unit
    import retire_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  retire_lane_t [NUM_LANES-1:0] i_lanes,
    output word_t                        o_hi,
    output word_t                        o_lo
);

    dword_t [NUM_LANES-1:0] lane_res;
    logic                   hi_write;
    logic                   lo_write;
    word_t                  hi_data;
    word_t                  lo_data;

    // candidate HI:LO per lane, always against the old pair
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            case (i_lanes[i].hilo_op)
                HILO_ADD: lane_res[i] = {o_hi, o_lo} + i_lanes[i].alu_out;
                HILO_SUB: lane_res[i] = {o_hi, o_lo} - i_lanes[i].alu_out;
                default: begin
                    if (i_lanes[i].srca) begin
                        lane_res[i] = {i_lanes[i].reg_data, i_lanes[i].reg_data};
                    end else begin
                        lane_res[i] = i_lanes[i].alu_out;
                    end
                end
            endcase
        end
    end

    // older lane first, lane 0 overrides
    always_comb begin
        hi_write = 1'b0;
        lo_write = 1'b0;
        hi_data  = o_hi;
        lo_data  = o_lo;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (i_lanes[i].valid && i_lanes[i].hiwrite) begin
                hi_write = 1'b1;
                hi_data  = lane_res[i][2*WORD_W-1:WORD_W];
            end
            if (i_lanes[i].valid && i_lanes[i].lowrite) begin
                lo_write = 1'b1;
                lo_data  = lane_res[i][WORD_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_hi <= '0;
            o_lo <= '0;
        end else begin
            if (hi_write) begin
                o_hi <= hi_data;
            end
            if (lo_write) begin
                o_lo <= lo_data;
            end
        end
    end

endmodule

/* design/pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg
    import retire_pkg::*;
#(
    parameter type T = logic
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_flush,
    input  T [NUM_LANES-1:0]     i_lanes,
    output T [NUM_LANES-1:0]     o_lanes
);

    // always enabled, a flush drops both lanes at once
    always_ff @(posedge clk) begin
        if (reset || i_flush) begin
            // zero record carries valid = 0
            o_lanes <= '0;
        end else begin
            o_lanes <= i_lanes;
        end
    end

endmodule

/* design/reg_write_if.sv */
`timescale 1ns/1ps

interface reg_write_if
    import retire_pkg::*;
();

    // one entry per lane, lane 1 older than lane 0
    logic      [NUM_LANES-1:0] wvalid;
    reg_addr_t [NUM_LANES-1:0] wa;
    word_t     [NUM_LANES-1:0] wd;

    // writeback side
    modport source (
        output wvalid,
        output wa,
        output wd
    );

    // register file side
    modport sink (
        input wvalid,
        input wa,
        input wd
    );

endinterface

/* design/regfile.sv */
`timescale 1ns/1ps

module regfile
    import retire_pkg::*;
#(
    parameter int REG_COUNT = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    reg_write_if.sink             wr,
    input  reg_addr_t [1:0]       i_ra,
    output word_t     [1:0]       o_rd
);

    localparam int NUM_READ = 2;
    // smaller files just use the low address bits
    localparam int AW = $clog2(REG_COUNT);

    word_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '{default: '0};
        end else begin
            // lane 1 first so the younger lane 0 lands last
            for (int i = NUM_LANES - 1; i >= 0; i--) begin
                if (wr.wvalid[i] && (wr.wa[i][AW-1:0] != '0)) begin
                    regs[wr.wa[i][AW-1:0]] <= wr.wd[i];
                end
            end
        end
    end

    // async read, same-cycle write not visible yet
    always_comb begin
        for (int p = 0; p < NUM_READ; p++) begin
            if (i_ra[p][AW-1:0] == '0) begin
                o_rd[p] = '0;
            end else begin
                o_rd[p] = regs[i_ra[p][AW-1:0]];
            end
        end
    end

endmodule

/* design/retire_core.sv */
`timescale 1ns/1ps

module retire_core
    import retire_pkg::*;
#(
    parameter int REG_COUNT = 32
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         i_flush,
    input  retire_lane_t [NUM_LANES-1:0] i_lanes,
    input  reg_addr_t    [1:0]           i_ra,
    output word_t        [1:0]           o_rd,
    output word_t                        o_hi,
    output word_t                        o_lo
);

    // lanes after the last stage register
    retire_lane_t [NUM_LANES-1:0] staged_lanes;

    // writeback to register file
    reg_write_if wr_if ();

    pipe_reg #(
        .T (retire_lane_t)
    ) stage_reg_i (
        .clk     (clk),
        .reset   (reset),
        .i_flush (i_flush),
        .i_lanes (i_lanes),
        .o_lanes (staged_lanes)
    );

    // hi/lo feed back before their update
    writeback writeback_i (
        .i_lanes (staged_lanes),
        .i_hi    (o_hi),
        .i_lo    (o_lo),
        .wr      (wr_if)
    );

    hilo_unit hilo_unit_i (
        .clk     (clk),
        .reset   (reset),
        .i_lanes (staged_lanes),
        .o_hi    (o_hi),
        .o_lo    (o_lo)
    );

    regfile #(
        .REG_COUNT (REG_COUNT)
    ) regfile_i (
        .clk   (clk),
        .reset (reset),
        .wr    (wr_if),
        .i_ra  (i_ra),
        .o_rd  (o_rd)
    );

endmodule

/* design/retire_pkg.sv */
package retire_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;

    // two lanes only, the HI/LO priority order depends on it
    localparam int NUM_LANES = 2;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [2*WORD_W-1:0]   dword_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // accumulate mode for HI:LO updates
    typedef enum logic [1:0] {
        HILO_NONE,
        HILO_ADD,
        HILO_SUB
    } hilo_op_t;

    // one retiring instruction, all zeros means an empty slot
    typedef struct packed {
        logic      valid;
        logic      regwrite;
        reg_addr_t wa;
        logic      memtoreg;
        logic      hitoreg;
        logic      lotoreg;
        logic      hiwrite;
        logic      lowrite;
        // load HI/LO from reg_data instead of alu_out
        logic      srca;
        hilo_op_t  hilo_op;
        word_t     reg_data;
        word_t     mem_data;
        dword_t    alu_out;
    } retire_lane_t;

endpackage

/* design/writeback.sv */
`timescale 1ns/1ps

module writeback
    import retire_pkg::*;
(
    input  retire_lane_t [NUM_LANES-1:0] i_lanes,
    input  word_t                        i_hi,
    input  word_t                        i_lo,
    reg_write_if.source                  wr
);

    word_t [NUM_LANES-1:0] result;

    // result select, memory data has top priority
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (i_lanes[i].memtoreg) begin
                result[i] = i_lanes[i].mem_data;
            end else if (i_lanes[i].lotoreg) begin
                // pre-update LO
                result[i] = i_lo;
            end else if (i_lanes[i].hitoreg) begin
                result[i] = i_hi;
            end else begin
                result[i] = i_lanes[i].alu_out[WORD_W-1:0];
            end
        end
    end

    // register 0 is dropped inside the register file
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            wr.wvalid[i] = i_lanes[i].valid && i_lanes[i].regwrite;
            wr.wa[i]     = i_lanes[i].wa;
            wr.wd[i]     = result[i];
        end
    end

endmodule

/* testbench/retire_checker.sv */
`timescale 1ns/1ps

module retire_checker
    import retire_pkg::*;
(
    input logic                         clk,
    input logic                         reset,
    input reg_addr_t    [1:0]           i_ra,
    input word_t        [1:0]           o_rd,
    input word_t                        o_hi,
    input word_t                        o_lo,
    input retire_lane_t [NUM_LANES-1:0] i_staged
);

    logic hi_wr;
    logic lo_wr;

    // any staged lane updating HI or LO this edge
    assign hi_wr = (i_staged[0].valid && i_staged[0].hiwrite) ||
                   (i_staged[1].valid && i_staged[1].hiwrite);
    assign lo_wr = (i_staged[0].valid && i_staged[0].lowrite) ||
                   (i_staged[1].valid && i_staged[1].lowrite);

    // register 0 always reads as zero
    rd0_zero_a: assert property (@(posedge clk) disable iff (reset)
        (i_ra[0] == '0) |-> (o_rd[0] == '0))
        else $error("read port 0 returned nonzero data for register 0");

    rd1_zero_a: assert property (@(posedge clk) disable iff (reset)
        (i_ra[1] == '0) |-> (o_rd[1] == '0))
        else $error("read port 1 returned nonzero data for register 0");

    hi_hold_a: assert property (@(posedge clk) disable iff (reset)
        !hi_wr |=> $stable(o_hi))
        else $error("HI changed without a staged hiwrite");

    lo_hold_a: assert property (@(posedge clk) disable iff (reset)
        !lo_wr |=> $stable(o_lo))
        else $error("LO changed without a staged lowrite");

    hilo_reset_a: assert property (@(posedge clk)
        reset |=> (o_hi == '0 && o_lo == '0))
        else $error("HI or LO not cleared by reset");

endmodule

bind retire_core retire_checker checker_i (
    .clk      (clk),
    .reset    (reset),
    .i_ra     (i_ra),
    .o_rd     (o_rd),
    .o_hi     (o_hi),
    .o_lo     (o_lo),
    .i_staged (staged_lanes)
);

/* testbench/tb_retire.sv */
`timescale 1ns/1ps

module tb_retire
    import retire_pkg::*;
;

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 16;
    localparam int NUM_TESTS      = 6;
    localparam int TEST_LEN       = 40;
    localparam int DRAIN          = 3;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * TEST_LEN + 100;

    typedef retire_lane_t [NUM_LANES-1:0] lane_pair_t;
    typedef reg_addr_t [1:0]              ra_pair_t;

    logic       clk;
    logic       reset;
    logic       i_flush;
    lane_pair_t i_lanes;
    ra_pair_t   i_ra;
    word_t      [1:0] o_rd;
    word_t      o_hi;
    word_t      o_lo;

    // reference state and pending cycles
    word_t        model_regs [32];
    word_t        model_hi;
    word_t        model_lo;
    lane_pair_t   lane_q [$];
    logic         flush_q [$];
    string        name_q [$];
    string        cur_name = "reset";
    ra_pair_t     wa_hist1 = '0;
    ra_pair_t     wa_hist2 = '0;
    logic [31:0]  lcg_state = 32'h4e98_10b5;
    int           rd_errors = 0;
    int           hilo_errors = 0;
    int           cycle_count = 0;

    string test_names [NUM_TESTS] = '{"alu_write", "same_target", "hilo_load",
                                      "hilo_accumulate", "mem_and_disabled", "flush"};

    retire_core #(
        .REG_COUNT (32)
    ) dut_i (
        .clk     (clk),
        .reset   (reset),
        .i_flush (i_flush),
        .i_lanes (i_lanes),
        .i_ra    (i_ra),
        .o_rd    (o_rd),
        .o_hi    (o_hi),
        .o_lo    (o_lo)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // random lane shaped by the test in progress
    function automatic retire_lane_t make_lane(input int test_id, input int lane, input int cyc);
        retire_lane_t l;
        word_t        r;
        l          = '0;
        l.reg_data = next_rand();
        l.mem_data = next_rand();
        l.alu_out  = {next_rand(), next_rand()};
        r          = next_rand();
        l.wa       = r[31:27];
        case (test_id)
            0: begin
                // lane 1 left invalid with regwrite set
                l.valid    = (lane == 0);
                l.regwrite = 1'b1;
                if (cyc % 8 == 0) begin
                    l.wa = '0;
                end
            end
            1: begin
                l.valid    = 1'b1;
                l.regwrite = 1'b1;
            end
            2: begin
                l.valid = 1'b1;
                if (lane == 1) begin
                    l.hiwrite = r[20];
                    l.lowrite = r[21] | ~r[20];
                    l.srca    = r[22];
                end else begin
                    l.regwrite = 1'b1;
                    l.hitoreg  = r[20];
                    l.lotoreg  = ~r[20];
                end
            end
            3: begin
                l.valid    = 1'b1;
                l.hiwrite  = r[20];
                l.lowrite  = r[21];
                l.hilo_op  = r[22] ? HILO_SUB : HILO_ADD;
                l.regwrite = r[23];
                l.hitoreg  = r[24];
                l.lotoreg  = r[25];
            end
            4: begin
                l.valid    = r[20] | r[21];
                l.regwrite = r[22] | r[23];
                l.memtoreg = r[24];
            end
            default: begin
                l.valid    = r[20];
                l.regwrite = r[21];
                l.memtoreg = r[22];
                l.hitoreg  = r[23];
                l.lotoreg  = r[24];
                l.hiwrite  = r[25];
                l.lowrite  = r[26];
                l.srca     = r[19];
                l.hilo_op  = hilo_op_t'(r[18:16] % 3);
            end
        endcase
        return l;
    endfunction

    // expected register file and HI:LO after one retired cycle
    function automatic void apply_cycle(input lane_pair_t lanes, input logic flush);
        word_t  old_hi;
        word_t  old_lo;
        word_t  res;
        dword_t acc;
        word_t  hi_src;
        word_t  lo_src;
        if (flush) begin
            return;
        end
        old_hi = model_hi;
        old_lo = model_lo;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (lanes[i].memtoreg) begin
                res = lanes[i].mem_data;
            end else if (lanes[i].lotoreg) begin
                res = old_lo;
            end else if (lanes[i].hitoreg) begin
                res = old_hi;
            end else begin
                res = lanes[i].alu_out[31:0];
            end
            if (lanes[i].valid && lanes[i].regwrite && lanes[i].wa != 5'd0) begin
                model_regs[lanes[i].wa] = res;
            end
            case (lanes[i].hilo_op)
                HILO_ADD: acc = {old_hi, old_lo} + lanes[i].alu_out;
                HILO_SUB: acc = {old_hi, old_lo} - lanes[i].alu_out;
                default:  acc = lanes[i].alu_out;
            endcase
            hi_src = (lanes[i].hilo_op == HILO_NONE && lanes[i].srca) ? lanes[i].reg_data
                                                                       : acc[63:32];
            lo_src = (lanes[i].hilo_op == HILO_NONE && lanes[i].srca) ? lanes[i].reg_data
                                                                       : acc[31:0];
            if (lanes[i].valid && lanes[i].hiwrite) begin
                model_hi = hi_src;
            end
            if (lanes[i].valid && lanes[i].lowrite) begin
                model_lo = lo_src;
            end
        end
    endfunction

    // read back the targets written two cycles earlier
    task automatic drive_cycle(input lane_pair_t lanes, input logic flush, input string name);
        i_lanes  = lanes;
        i_flush  = flush;
        i_ra     = wa_hist2;
        wa_hist2 = wa_hist1;
        wa_hist1 = {lanes[1].wa, lanes[0].wa};
        lane_q.push_back(lanes);
        flush_q.push_back(flush);
        name_q.push_back(name);
    endtask

    initial begin : stimulus
        lane_pair_t lanes;
        logic       flush;
        word_t      r;
        reset   = 1'b1;
        i_flush = 1'b0;
        i_lanes = '0;
        i_ra    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int c = 0; c < TEST_LEN; c++) begin
                @(negedge clk);
                lanes[1] = make_lane(t, 1, c);
                lanes[0] = make_lane(t, 0, c);
                r        = next_rand();
                if (t == 1 && c % 2 == 0) begin
                    lanes[0].wa = lanes[1].wa;
                end
                // both lanes hit HI and LO together
                if (t == 3 && c % 4 == 0) begin
                    lanes[1].hiwrite = 1'b1;
                    lanes[1].lowrite = 1'b1;
                    lanes[0].hiwrite = 1'b1;
                    lanes[0].lowrite = 1'b1;
                end
                flush = (t == 5) && (r[29:28] == 2'b00);
                drive_cycle(lanes, flush, test_names[t]);
            end
        end
        repeat (DRAIN) begin
            @(negedge clk);
            drive_cycle('0, 1'b0, "drain");
        end
        @(negedge clk);
        #10;
        $display("errors: register reads %0d, hi/lo %0d", rd_errors, hilo_errors);
        if (rd_errors + hilo_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin : compare
        word_t exp_rd;
        foreach (model_regs[k]) begin
            model_regs[k] = '0;
        end
        model_hi = '0;
        model_lo = '0;
        wait (reset == 1'b0);
        forever begin
            @(negedge clk);
            #5;
            while (lane_q.size() > 2) begin
                apply_cycle(lane_q.pop_front(), flush_q.pop_front());
                cur_name = name_q.pop_front();
            end
            for (int p = 0; p < 2; p++) begin
                exp_rd = (i_ra[p] == 5'd0) ? 32'd0 : model_regs[i_ra[p]];
                assert (o_rd[p] === exp_rd) else begin
                    rd_errors++;
                    $display("[ERROR] %s: o_rd[%0d] r%0d expected %h, actual %h",
                             cur_name, p, i_ra[p], exp_rd, o_rd[p]);
                end
            end
            assert (o_hi === model_hi) else begin
                hilo_errors++;
                $display("[ERROR] %s: o_hi expected %h, actual %h", cur_name, model_hi, o_hi);
            end
            assert (o_lo === model_lo) else begin
                hilo_errors++;
                $display("[ERROR] %s: o_lo expected %h, actual %h", cur_name, model_lo, o_lo);
            end
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            cycle_count <= cycle_count + 1;
        end
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: register reads %0d, hi/lo %0d", rd_errors, hilo_errors);
            $display("Regression failed");
            $finish;
        end
    end

endmodule

/* vlog.f */
design/retire_pkg.sv
design/reg_write_if.sv
design/pipe_reg.sv
design/regfile.sv
design/hilo_unit.sv
design/writeback.sv
design/retire_core.sv
testbench/retire_checker.sv
testbench/tb_retire.sv
